//--- Makefile
TOP := tb_dual_issue_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+common
common/core_pkg.sv
hdl/reg_file.sv
lane/inst_decode.sv
lane/exec_lane.sv
hdl/writeback_merge.sv
hdl/dual_issue_core.sv
tb/tb_dual_issue_core.sv

//--- common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and register file sizes
`define XLEN      32
`define REG_AW    5
`define NUM_REGS  32

// opcode field widths, 3R and 2RI12 formats
`define OP3_W     17
`define OPI_W     10

//////////////////////////////
// 3R opcodes, inst[31:15]
//////////////////////////////
`define OP_ADD_W  17'h00020
`define OP_SUB_W  17'h00022
`define OP_SLT    17'h00024
`define OP_SLTU   17'h00025
`define OP_AND    17'h00029
`define OP_OR     17'h0002A
`define OP_XOR    17'h0002B

//////////////////////////////
// 2RI12 opcodes, inst[31:22]
//////////////////////////////
`define OP_SLTI   10'h008
`define OP_SLTUI  10'h009
`define OP_ADDI_W 10'h00A
`define OP_ANDI   10'h00D
`define OP_ORI    10'h00E
`define OP_XORI   10'h00F

// byte enables on the debug port for a full word write
`define DBG_WE_ALL 4'hF

`endif

//--- common/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    //////////////////////////////
    // instruction word views
    //////////////////////////////
    typedef struct packed {
        logic [`OP3_W-1:0]  opcode;
        logic [`REG_AW-1:0] rk;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } reg3_fmt_t;

    typedef struct packed {
        logic [`OPI_W-1:0]  opcode;
        logic [11:0]        imm12;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } ri12_fmt_t;

    // same 32 bits, decoded as either format
    typedef union packed {
        reg3_fmt_t reg3;
        ri12_fmt_t ri12;
    } instr_word_u;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        instr_word_u      ir;
    } issue_slot_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        alu_op_e            op;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rk;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   imm;
        logic               use_imm;
        logic               rf_we;
    } decoded_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
        logic [`XLEN-1:0]   pc;
    } lane_result_t;

    // same fields as the debug0/debug1 writeback ports
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [3:0]         rf_we;
        logic [`REG_AW-1:0] rf_wnum;
        logic [`XLEN-1:0]   rf_wdata;
    } debug_wb_t;

endpackage

//--- hdl/dual_issue_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module dual_issue_core
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  issue_slot_t i_slot0,
    input  issue_slot_t i_slot1,
    output debug_wb_t   o_debug0,
    output debug_wb_t   o_debug1
);
    // lane 0 on ports a, lane 1 on ports b
    logic [`REG_AW-1:0] raddr_a1, raddr_a2, raddr_b1, raddr_b2;
    logic [`XLEN-1:0]   rdata_a1, rdata_a2, rdata_b1, rdata_b2;
    logic               we_a, we_b;
    logic [`REG_AW-1:0] waddr_a, waddr_b;
    logic [`XLEN-1:0]   wdata_a, wdata_b;
    lane_result_t       res0, res1;

    exec_lane u_lane0 (
        .i_slot (i_slot0), .o_raddr1 (raddr_a1), .o_raddr2 (raddr_a2),
        .i_rdata1 (rdata_a1), .i_rdata2 (rdata_a2), .o_result (res0)
    );

    exec_lane u_lane1 (
        .i_slot (i_slot1), .o_raddr1 (raddr_b1), .o_raddr2 (raddr_b2),
        .i_rdata1 (rdata_b1), .i_rdata2 (rdata_b2), .o_result (res1)
    );

    reg_file u_rf (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_raddr_a1 (raddr_a1), .i_raddr_a2 (raddr_a2),
        .i_raddr_b1 (raddr_b1), .i_raddr_b2 (raddr_b2),
        .o_rdata_a1 (rdata_a1), .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1), .o_rdata_b2 (rdata_b2),
        .i_we_a (we_a), .i_we_b (we_b),
        .i_waddr_a (waddr_a), .i_waddr_b (waddr_b),
        .i_wdata_a (wdata_a), .i_wdata_b (wdata_b)
    );

    writeback_merge u_wb (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_res0 (res0), .i_res1 (res1),
        .o_we_a (we_a), .o_we_b (we_b),
        .o_waddr_a (waddr_a), .o_waddr_b (waddr_b),
        .o_wdata_a (wdata_a), .o_wdata_b (wdata_b),
        .o_debug0 (o_debug0), .o_debug1 (o_debug1)
    );

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_file (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic [`REG_AW-1:0] i_raddr_a1,
    input  logic [`REG_AW-1:0] i_raddr_a2,
    input  logic [`REG_AW-1:0] i_raddr_b1,
    input  logic [`REG_AW-1:0] i_raddr_b2,
    output logic [`XLEN-1:0]   o_rdata_a1,
    output logic [`XLEN-1:0]   o_rdata_a2,
    output logic [`XLEN-1:0]   o_rdata_b1,
    output logic [`XLEN-1:0]   o_rdata_b2,
    input  logic               i_we_a,
    input  logic               i_we_b,
    input  logic [`REG_AW-1:0] i_waddr_a,
    input  logic [`REG_AW-1:0] i_waddr_b,
    input  logic [`XLEN-1:0]   i_wdata_a,
    input  logic [`XLEN-1:0]   i_wdata_b
);
    // r0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    function automatic logic [`XLEN-1:0] rd_port(input logic [`REG_AW-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    assign o_rdata_a1 = rd_port(i_raddr_a1);
    assign o_rdata_a2 = rd_port(i_raddr_a2);
    assign o_rdata_b1 = rd_port(i_raddr_b1);
    assign o_rdata_b2 = rd_port(i_raddr_b2);

    // ports a and b never target the same register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_we_a && i_waddr_a != '0)
                regs[i_waddr_a] <= i_wdata_a;
            if (i_we_b && i_waddr_b != '0)
                regs[i_waddr_b] <= i_wdata_b;
        end
    end

endmodule

//--- hdl/writeback_merge.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module writeback_merge
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               i_arst_n,
    input  lane_result_t       i_res0,
    input  lane_result_t       i_res1,
    output logic               o_we_a,
    output logic               o_we_b,
    output logic [`REG_AW-1:0] o_waddr_a,
    output logic [`REG_AW-1:0] o_waddr_b,
    output logic [`XLEN-1:0]   o_wdata_a,
    output logic [`XLEN-1:0]   o_wdata_b,
    output debug_wb_t          o_debug0,
    output debug_wb_t          o_debug1
);
    logic same_dst;

    function automatic debug_wb_t to_debug(input lane_result_t res);
        debug_wb_t rec;
        rec.pc       = res.pc;
        rec.rf_we    = res.we ? `DBG_WE_ALL : 4'h0;
        rec.rf_wnum  = res.waddr;
        rec.rf_wdata = res.wdata;
        return rec;
    endfunction

    //////////////////////////////
    // register file writes
    //////////////////////////////
    // slot 1 is younger, so its value wins
    assign same_dst  = i_res0.we && i_res1.we && (i_res0.waddr == i_res1.waddr)
                       && (i_res0.waddr != '0);
    assign o_we_a    = i_res0.we & ~same_dst;
    assign o_waddr_a = i_res0.waddr;
    assign o_wdata_a = i_res0.wdata;
    assign o_we_b    = i_res1.we;
    assign o_waddr_b = i_res1.waddr;
    assign o_wdata_b = i_res1.wdata;

    // debug records show both writes, even a suppressed one
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_debug0 <= '0;
            o_debug1 <= '0;
        end else begin
            o_debug0 <= to_debug(i_res0);
            o_debug1 <= to_debug(i_res1);
        end
    end

endmodule

//--- lane/exec_lane.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_lane
    import core_pkg::*;
(
    input  issue_slot_t        i_slot,
    output logic [`REG_AW-1:0] o_raddr1,
    output logic [`REG_AW-1:0] o_raddr2,
    input  logic [`XLEN-1:0]   i_rdata1,
    input  logic [`XLEN-1:0]   i_rdata2,
    output lane_result_t       o_result
);
    decoded_t         dec;
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic [`XLEN-1:0] alu_out;

    inst_decode u_dec (
        .i_ir  (i_slot.ir),
        .o_dec (dec)
    );

    assign o_raddr1 = dec.rj;
    assign o_raddr2 = dec.rk;

    // operand select
    assign src1 = i_rdata1;
    assign src2 = dec.use_imm ? dec.imm : i_rdata2;

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (dec.op)
            ALU_ADD:  alu_out = src1 + src2;
            ALU_SUB:  alu_out = src1 - src2;
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, ($signed(src1) < $signed(src2))};
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, (src1 < src2)};
            ALU_AND:  alu_out = src1 & src2;
            ALU_OR:   alu_out = src1 | src2;
            ALU_XOR:  alu_out = src1 ^ src2;
            default:  alu_out = '0;
        endcase
    end

    // only a valid slot with a known opcode writes
    assign o_result.we    = i_slot.valid & dec.rf_we;
    assign o_result.waddr = dec.rd;
    assign o_result.wdata = alu_out;
    assign o_result.pc    = i_slot.pc;

endmodule

//--- lane/inst_decode.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module inst_decode
    import core_pkg::*;
(
    input  instr_word_u i_ir,
    output decoded_t    o_dec
);
    logic [`XLEN-1:0] imm_sext;
    logic [`XLEN-1:0] imm_zext;
    logic             hit_reg3;

    assign imm_sext = {{(`XLEN-12){i_ir.ri12.imm12[11]}}, i_ir.ri12.imm12};
    assign imm_zext = {{(`XLEN-12){1'b0}}, i_ir.ri12.imm12};

    //////////////////////////////
    // 3R format
    //////////////////////////////
    always_comb begin
        hit_reg3  = 1'b1;
        o_dec.op  = ALU_ADD;
        case (i_ir.reg3.opcode)
            `OP_ADD_W: o_dec.op = ALU_ADD;
            `OP_SUB_W: o_dec.op = ALU_SUB;
            `OP_SLT:   o_dec.op = ALU_SLT;
            `OP_SLTU:  o_dec.op = ALU_SLTU;
            `OP_AND:   o_dec.op = ALU_AND;
            `OP_OR:    o_dec.op = ALU_OR;
            `OP_XOR:   o_dec.op = ALU_XOR;
            default:   hit_reg3 = 1'b0;
        endcase

        // register fields sit at the same bits in both views
        o_dec.rj      = i_ir.reg3.rj;
        o_dec.rk      = i_ir.reg3.rk;
        o_dec.rd      = i_ir.reg3.rd;
        o_dec.imm     = '0;
        o_dec.use_imm = 1'b0;
        o_dec.rf_we   = hit_reg3;

        //////////////////////////////
        // 2RI12 format
        //////////////////////////////
        if (!hit_reg3) begin
            o_dec.use_imm = 1'b1;
            o_dec.rf_we   = 1'b1;
            o_dec.imm     = imm_sext;
            case (i_ir.ri12.opcode)
                `OP_ADDI_W: o_dec.op = ALU_ADD;
                `OP_SLTI:   o_dec.op = ALU_SLT;
                `OP_SLTUI:  o_dec.op = ALU_SLTU;
                `OP_ANDI: begin
                    o_dec.op  = ALU_AND;
                    o_dec.imm = imm_zext;
                end
                `OP_ORI: begin
                    o_dec.op  = ALU_OR;
                    o_dec.imm = imm_zext;
                end
                `OP_XORI: begin
                    o_dec.op  = ALU_XOR;
                    o_dec.imm = imm_zext;
                end
                // unknown word, no write
                default: o_dec.rf_we = 1'b0;
            endcase
        end
    end

endmodule

//--- tb/tb_dual_issue_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_dual_issue_core
    import core_pkg::*;
();
    localparam int NUM_ENTRIES = 20;
    localparam int IDLE_LIMIT  = 10;

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_XOR,
        K_SLTI, K_SLTUI, K_ADDI, K_ANDI, K_ORI, K_XORI, K_BAD
    } kind_e;

    typedef struct packed {
        logic        valid;
        kind_e       kind;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] imm;
    } op_t;

    logic        clk;
    logic        arst_n;
    issue_slot_t slot0;
    issue_slot_t slot1;
    debug_wb_t   debug0;
    debug_wb_t   debug1;
    op_t         tbl0 [NUM_ENTRIES];
    op_t         tbl1 [NUM_ENTRIES];
    // reference register state
    logic [31:0] ref_regs [`NUM_REGS];

    dual_issue_core i_dut (
        .clk (clk), .i_arst_n (arst_n),
        .i_slot0 (slot0), .i_slot1 (slot1),
        .o_debug0 (debug0), .o_debug1 (debug1)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // instruction building
    //////////////////////////////
    function automatic op_t rr(input kind_e kind, input int rd, input int rj, input int rk);
        op_t op;
        op.valid = 1'b1;
        op.kind  = kind;
        op.rd    = rd[4:0];
        op.rj    = rj[4:0];
        op.rk    = rk[4:0];
        op.imm   = 12'h0;
        return op;
    endfunction

    function automatic op_t ri(input kind_e kind, input int rd, input int rj, input int imm);
        op_t op;
        op     = rr(kind, rd, rj, 0);
        op.imm = imm[11:0];
        return op;
    endfunction

    function automatic op_t off(input op_t op);
        op_t res;
        res       = op;
        res.valid = 1'b0;
        return res;
    endfunction

    function automatic instr_word_u encode(input op_t op);
        instr_word_u w;
        w = '0;
        case (op.kind)
            K_ADD:   w.reg3.opcode = `OP_ADD_W;
            K_SUB:   w.reg3.opcode = `OP_SUB_W;
            K_SLT:   w.reg3.opcode = `OP_SLT;
            K_SLTU:  w.reg3.opcode = `OP_SLTU;
            K_AND:   w.reg3.opcode = `OP_AND;
            K_OR:    w.reg3.opcode = `OP_OR;
            K_XOR:   w.reg3.opcode = `OP_XOR;
            K_SLTI:  w.ri12.opcode = `OP_SLTI;
            K_SLTUI: w.ri12.opcode = `OP_SLTUI;
            K_ADDI:  w.ri12.opcode = `OP_ADDI_W;
            K_ANDI:  w.ri12.opcode = `OP_ANDI;
            K_ORI:   w.ri12.opcode = `OP_ORI;
            K_XORI:  w.ri12.opcode = `OP_XORI;
            // matches neither format
            default: w = 32'hFFFF_FFFF;
        endcase
        if (op.kind != K_BAD) begin
            if (op.kind >= K_SLTI)
                w.ri12.imm12 = op.imm;
            else
                w.reg3.rk = op.rk;
            w.reg3.rj = op.rj;
            w.reg3.rd = op.rd;
        end
        return w;
    endfunction

    // expected result from the instruction set rules
    function automatic logic [31:0] model_result(input op_t op, input logic [31:0] a,
                                                 input logic [31:0] rk_val);
        logic [31:0] b;
        case (op.kind)
            K_SLTI, K_SLTUI, K_ADDI: b = {{20{op.imm[11]}}, op.imm};
            K_ANDI, K_ORI, K_XORI:   b = {20'h0, op.imm};
            default:                 b = rk_val;
        endcase
        case (op.kind)
            K_ADD, K_ADDI:   return a + b;
            K_SUB:           return a - b;
            K_SLT, K_SLTI:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLTU, K_SLTUI: return (a < b) ? 32'd1 : 32'd0;
            K_AND, K_ANDI:   return a & b;
            K_OR, K_ORI:     return a | b;
            K_XOR, K_XORI:   return a ^ b;
            default:         return 32'h0;
        endcase
    endfunction

    task automatic set_entry(input int idx, input op_t s0, input op_t s1);
        tbl0[idx] = s0;
        tbl1[idx] = s1;
    endtask

    // slot 1 never reads slot 0's destination within one entry
    task automatic load_table();
        set_entry(0,  ri(K_ADDI, 1, 0, 'h123),    ri(K_ADDI, 2, 0, -5));
        set_entry(1,  ri(K_ADDI, 3, 0, 'h7ff),    ri(K_ADDI, 4, 0, -2048));
        set_entry(2,  rr(K_ADD, 5, 1, 2),         rr(K_SUB, 6, 3, 4));
        set_entry(3,  rr(K_AND, 7, 2, 3),         rr(K_OR, 8, 1, 4));
        set_entry(4,  rr(K_XOR, 9, 7, 8),         rr(K_SLT, 10, 2, 1));
        set_entry(5,  rr(K_SLTU, 11, 2, 1),       rr(K_SLT, 12, 1, 2));
        set_entry(6,  ri(K_SLTI, 13, 1, -1),      ri(K_SLTUI, 14, 2, -1));
        set_entry(7,  ri(K_ANDI, 15, 2, 'hf0f),   ri(K_ORI, 16, 0, 'h800));
        set_entry(8,  ri(K_XORI, 17, 2, 'h8aa),   ri(K_ADDI, 18, 4, -1));
        // same destination, then a write to r0
        set_entry(9,  ri(K_ADDI, 20, 0, 'h11),    ri(K_ADDI, 20, 0, 'h22));
        set_entry(10, rr(K_ADD, 21, 20, 0),       ri(K_ADDI, 0, 1, 'h55));
        set_entry(11, rr(K_ADD, 22, 0, 1),        rr(K_SUB, 23, 20, 0));
        set_entry(12, off(ri(K_ADDI, 1, 0, 'h3ab)), rr(K_BAD, 2, 0, 0));
        set_entry(13, rr(K_ADD, 24, 1, 2),        rr(K_XOR, 25, 1, 2));
        set_entry(14, ri(K_SLTI, 26, 4, -2047),   ri(K_SLTUI, 27, 2, 5));
        set_entry(15, rr(K_SUB, 28, 0, 1),        rr(K_SLTU, 29, 0, 2));
        set_entry(16, rr(K_OR, 30, 28, 29),       rr(K_AND, 31, 28, 2));
        set_entry(17, ri(K_ADDI, 1, 1, -1),       ri(K_ADDI, 2, 2, 1));
        set_entry(18, rr(K_ADD, 3, 1, 2),         rr(K_SLT, 4, 2, 1));
        set_entry(19, off(rr(K_ADD, 5, 1, 2)),    off(ri(K_ORI, 6, 0, 'hfff)));
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            stop_on_failure("a DUT output did not match the reference model");
        end
    endtask

    task automatic check_port(input string port, input int idx, input debug_wb_t act,
                              input logic [31:0] pc, input logic we, input op_t op,
                              input logic [31:0] wdata);
        check_value($sformatf("entry %0d %s.pc", idx, port), pc, act.pc);
        check_value($sformatf("entry %0d %s.rf_we", idx, port),
                    {28'h0, (we ? `DBG_WE_ALL : 4'h0)}, {28'h0, act.rf_we});
        if (we) begin
            check_value($sformatf("entry %0d %s.rf_wnum", idx, port),
                        {27'h0, op.rd}, {27'h0, act.rf_wnum});
            check_value($sformatf("entry %0d %s.rf_wdata", idx, port), wdata, act.rf_wdata);
        end
    endtask

    task automatic wait_for_idle(input string phase, input int limit);
        int   count;
        logic idle;
        count = 0;
        idle  = 1'b0;
        while (!idle) begin
            @(posedge clk);
            #1;
            count++;
            idle = (debug0.rf_we == 4'h0) && (debug1.rf_we == 4'h0);
            if (!idle && count >= limit)
                stop_on_failure($sformatf(
                    "timeout: debug ports still show writes during %s after %0d cycles",
                    phase, limit));
        end
    endtask

    // one pair in, one cycle later both debug records out
    task automatic run_entry(input int idx);
        op_t         s0;
        op_t         s1;
        logic [31:0] pc0;
        logic [31:0] pc1;
        logic [31:0] exp0;
        logic [31:0] exp1;
        logic        we0;
        logic        we1;
        s0   = tbl0[idx];
        s1   = tbl1[idx];
        pc0  = 32'h1c00_0000 + idx * 8;
        pc1  = pc0 + 32'd4;
        exp0 = model_result(s0, ref_regs[s0.rj], ref_regs[s0.rk]);
        exp1 = model_result(s1, ref_regs[s1.rj], ref_regs[s1.rk]);
        we0  = s0.valid && (s0.kind != K_BAD);
        we1  = s1.valid && (s1.kind != K_BAD);
        slot0.valid = s0.valid;
        slot0.pc    = pc0;
        slot0.ir    = encode(s0);
        slot1.valid = s1.valid;
        slot1.pc    = pc1;
        slot1.ir    = encode(s1);
        @(posedge clk);
        #1;
        check_port("o_debug0", idx, debug0, pc0, we0, s0, exp0);
        check_port("o_debug1", idx, debug1, pc1, we1, s1, exp1);
        // slot 0 first, then slot 1, with r0 held at zero
        if (we0 && s0.rd != 5'd0)
            ref_regs[s0.rd] = exp0;
        if (we1 && s1.rd != 5'd0)
            ref_regs[s1.rd] = exp1;
    endtask

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        slot0  = '0;
        slot1  = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            ref_regs[r] = 32'h0;
        end
        load_table();
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("o_debug0.rf_we after reset", 32'h0, {28'h0, debug0.rf_we});
        check_value("o_debug1.rf_we after reset", 32'h0, {28'h0, debug1.rf_we});
        wait_for_idle("reset", IDLE_LIMIT);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        slot0 = '0;
        slot1 = '0;
        wait_for_idle("drain", IDLE_LIMIT);
        $display("Result: PASSED");
        $finish;
    end

endmodule
